//--- compile.f
source/cpu_pkg.sv
source/cpu_decode.sv
source/cpu_sequencer.sv
source/cpu_alu.sv
source/cpu_regfile.sv
source/cpu_bus_master.sv
source/cpu_top.sv
dv/cpu_checker.sv
dv/cpu_tb.sv

//--- dv/cpu_checker.sv
module cpu_checker
(
    input  logic        clk,
    input  logic        reset,
    input  logic [15:0] wb_adr,
    input  logic [7:0]  wb_dat_w,
    input  logic [7:0]  wb_dat_r,
    input  logic        wb_we,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_ack,
    output int          error_count,
    output int          check_count
);

    typedef enum {ph_opcode, ph_opext, ph_imm_low, ph_imm_high, ph_mem} phase_e;

    phase_e      phase;
    logic [15:0] pc;
    logic [15:0] target;
    logic [7:0]  a;
    logic [7:0]  b;
    logic [7:0]  opcode;
    logic [7:0]  imm_low;
    logic        zero;
    logic        carry;
    logic        reset_q;
    logic        started;
    int          idle_cycles;
    int          busy_cycles;

    initial
    begin
        error_count = 0;
        check_count = 0;
        reset_q     = 1'b1;
    end

    // expected {known, carry, result} of A op B.
    function automatic logic [9:0] alu_ref(input logic [7:0] op, input logic [7:0] x,
                                           input logic [7:0] y);
        int         sum;
        logic [7:0] res;
        logic       cy;
        logic       known;
        known = 1'b1;
        cy    = 1'b0;
        res   = 8'h00;
        case (op)
            cpu_pkg::alu_add:
            begin
                sum = int'(x) + int'(y);
                res = sum[7:0];
                cy  = (sum > 255);                              // carry out of bit 7.
            end
            cpu_pkg::alu_sub:
            begin
                sum = int'(x) - int'(y);
                res = sum[7:0];
                cy  = (x < y);                                  // borrow.
            end
            cpu_pkg::alu_and: res = x & y;
            cpu_pkg::alu_or:  res = x | y;
            cpu_pkg::alu_xor: res = x ^ y;
            default:          known = 1'b0;
        endcase
        return {known, cy, res};
    endfunction

    task automatic compare(input string name, input logic [15:0] expected,
                           input logic [15:0] actual);
        check_count++;
        if (expected !== actual)
        begin
            error_count++;
            $display("ERR %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic model_reset;
        pc          = cpu_pkg::reset_vector;
        a           = 8'h00;
        b           = 8'h00;
        zero        = 1'b0;
        carry       = 1'b0;
        phase       = ph_opcode;
        started     = 1'b0;
        idle_cycles = 0;
        busy_cycles = 0;
    endtask

    // ##########################################################################
    // instruction model, one fetched byte at a time
    // ##########################################################################

    task automatic take_fetch(input logic [7:0] d);
        logic [9:0] r;
        pc = pc + 16'd1;
        case (phase)
            ph_opcode:
            begin
                opcode = d;
                case (d)
                    cpu_pkg::op_ext: phase = ph_opext;
                    cpu_pkg::op_ld_a_imm, cpu_pkg::op_ld_b_imm, cpu_pkg::op_st_a_mem,
                    cpu_pkg::op_ld_a_mem, cpu_pkg::op_jc, cpu_pkg::op_jz, cpu_pkg::op_jp:
                        phase = ph_imm_low;
                    default: phase = ph_opcode;                 // nop or unknown.
                endcase
            end
            ph_opext:
            begin
                r = alu_ref(d, a, b);
                if (r[9])
                begin
                    a     = r[7:0];
                    carry = r[8];
                    zero  = (r[7:0] == 8'h00);
                end
                phase = ph_opcode;
            end
            ph_imm_low:
            begin
                imm_low = d;
                phase   = ph_imm_high;
                if (opcode == cpu_pkg::op_ld_a_imm)
                begin
                    a     = d;
                    phase = ph_opcode;
                end
                else if (opcode == cpu_pkg::op_ld_b_imm)
                begin
                    b     = d;
                    phase = ph_opcode;
                end
            end
            ph_imm_high:
            begin
                target = {d, imm_low};
                phase  = ph_opcode;
                case (opcode)
                    cpu_pkg::op_st_a_mem, cpu_pkg::op_ld_a_mem: phase = ph_mem;
                    cpu_pkg::op_jp: pc = target;
                    cpu_pkg::op_jz: if (zero) pc = target;
                    cpu_pkg::op_jc: if (carry) pc = target;
                    default:        phase = ph_opcode;
                endcase
            end
            default: phase = ph_opcode;
        endcase
    endtask

    always @(posedge clk)
    begin
        if (reset)
        begin
            if (reset_q && wb_cyc)
            begin
                error_count++;
                $display("bus cycle still active while reset is held");
            end
            model_reset;
        end
        else
        begin
            if (wb_stb && !wb_cyc)
            begin
                error_count++;
                $display("strobe seen without cycle at address %h", wb_adr);
            end
            if (!started)
            begin
                if (wb_cyc)
                begin
                    started = 1'b1;
                    if (idle_cycles < cpu_pkg::reset_delay)
                    begin
                        error_count++;
                        $display("first bus cycle came %0d cycles after reset", idle_cycles);
                    end
                end
                else
                    idle_cycles++;
            end
            busy_cycles = wb_cyc ? busy_cycles + 1 : 0;
            if (busy_cycles == 64)
            begin
                error_count++;
                $display("bus cycle at address %h did not end within 64 cycles", wb_adr);
            end
            if (wb_cyc && wb_stb && wb_ack)
            begin
                if (phase == ph_mem)
                begin
                    compare("wb_adr", target, wb_adr);
                    compare("wb_we", opcode == cpu_pkg::op_st_a_mem, wb_we);
                    if (opcode == cpu_pkg::op_st_a_mem)
                        compare("wb_dat_w", a, wb_dat_w);
                    else
                        a = wb_dat_r;
                    phase = ph_opcode;
                end
                else
                begin
                    compare("wb_adr", pc, wb_adr);
                    compare("wb_we", 1'b0, wb_we);
                    take_fetch(wb_dat_r);
                end
            end
        end
        reset_q = reset;
    end

endmodule

//--- dv/cpu_tb.sv
module cpu_tb;

    logic        clk;
    logic        reset;
    logic [15:0] wb_adr;
    logic [7:0]  wb_dat_w;
    logic [7:0]  wb_dat_r;
    logic        wb_we;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_ack;
    logic [7:0]  mem [0:65535];
    logic [31:0] lfsr;
    logic [1:0]  wait_left;
    logic        in_access;
    logic        timed_out;
    logic [15:0] halt_addr;
    int          halt_hits;
    int          acks;
    int          error_count;
    int          check_count;
    int          errors_before;
    int          test_idx;

    cpu_top u_dut (.clk, .reset, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_we, .wb_cyc, .wb_stb,
                   .wb_ack);

    cpu_checker u_chk (.clk, .reset, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_we, .wb_cyc, .wb_stb,
                       .wb_ack, .error_count, .check_count);

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // taps 32, 22, 2, 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [7:0] take_bits(input int n);
        logic [7:0] v;
        v = 8'h00;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_step(lfsr);
            v    = {v[6:0], lfsr[0]};
        end
        return v;
    endfunction

    // ##########################################################################
    // wishbone memory with 0 to 3 wait states
    // ##########################################################################

    always @(negedge clk)
    begin
        if (wb_ack)
            wb_ack = 1'b0;
        else if (wb_cyc && wb_stb)
        begin
            if (!in_access)
            begin
                in_access = 1'b1;
                wait_left = 2'(take_bits(2));
            end
            if (wait_left == 2'd0)
            begin
                wb_ack    = 1'b1;
                in_access = 1'b0;
                acks++;
                if (wb_we)
                    mem[wb_adr] = wb_dat_w;
                else
                begin
                    wb_dat_r = mem[wb_adr];
                    if (wb_adr == halt_addr)
                        halt_hits++;
                end
            end
            else
                wait_left = wait_left - 2'd1;
        end
        else
            in_access = 1'b0;
    end

    task automatic put_byte(inout logic [15:0] p, input logic [7:0] d);
        mem[p] = d;
        p      = p + 16'd1;
    endtask

    // forward jumps land on instruction starts, padding runs as no-ops.
    task automatic gen_program;
        logic [15:0] p;
        logic [15:0] dest;
        logic [7:0]  sel;
        logic [7:0]  skip;
        p = 16'h0000;
        for (int i = 0; i < 65536; i++)
            mem[i] = i[7:0] ^ i[15:8] ^ 8'ha5;
        for (int i = 0; i < 32; i++)
            mem[16'h8000 + i] = take_bits(8);
        put_byte(p, cpu_pkg::op_ld_a_imm);
        put_byte(p, take_bits(8));
        put_byte(p, cpu_pkg::op_st_a_mem);
        put_byte(p, take_bits(5));
        put_byte(p, 8'h80);
        repeat (48)
        begin
            sel = take_bits(3);
            case (sel)
                8'd0, 8'd1:
                begin
                    put_byte(p, sel == 8'd0 ? cpu_pkg::op_ld_a_imm : cpu_pkg::op_ld_b_imm);
                    put_byte(p, take_bits(8));
                end
                8'd2, 8'd3:
                begin
                    put_byte(p, cpu_pkg::op_ext);
                    case (take_bits(3))
                        8'd0, 8'd5: put_byte(p, cpu_pkg::alu_add);
                        8'd1, 8'd6: put_byte(p, cpu_pkg::alu_sub);
                        8'd2:       put_byte(p, cpu_pkg::alu_and);
                        8'd3:       put_byte(p, cpu_pkg::alu_or);
                        8'd4:       put_byte(p, cpu_pkg::alu_xor);
                        default:    put_byte(p, 8'h18);         // unknown extension.
                    endcase
                end
                8'd4, 8'd5:
                begin
                    put_byte(p, sel == 8'd4 ? cpu_pkg::op_st_a_mem : cpu_pkg::op_ld_a_mem);
                    put_byte(p, take_bits(5));
                    put_byte(p, 8'h80);
                end
                8'd6:
                begin
                    sel  = take_bits(2);
                    skip = take_bits(3);
                    dest = p + 16'd3 + skip;
                    if (sel == 8'd0)
                        put_byte(p, cpu_pkg::op_jp);
                    else
                        put_byte(p, sel == 8'd1 ? cpu_pkg::op_jz : cpu_pkg::op_jc);
                    put_byte(p, dest[7:0]);
                    put_byte(p, dest[15:8]);
                    repeat (skip)
                        put_byte(p, take_bits(1) ? 8'h00 : 8'h5a);
                end
                default:
                    put_byte(p, take_bits(1) ? 8'h00 : 8'h3c);  // 3c is not an opcode.
            endcase
        end
        halt_addr = p;
        put_byte(p, cpu_pkg::op_jp);
        put_byte(p, halt_addr[7:0]);
        put_byte(p, halt_addr[15:8]);
    endtask

    task automatic apply_reset(input logic new_program);
        @(negedge clk);
        reset = 1'b1;
        @(posedge clk);
        if (new_program)
            gen_program;
        repeat (15) @(posedge clk);
        @(negedge clk);
        reset     = 1'b0;
        halt_hits = 0;
        acks      = 0;
    endtask

    task automatic wait_for_acks(input int count);
        int cycles;
        cycles = 0;
        while (acks < count && cycles < 5000)
        begin
            @(posedge clk);
            cycles++;
        end
        if (acks < count)
        begin
            $display("timeout after %0d cycles, only %0d bus cycles completed", cycles, acks);
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_for_halt;
        int cycles;
        cycles = 0;
        while (halt_hits < 2 && cycles < 20000)
        begin
            @(posedge clk);
            cycles++;
        end
        if (halt_hits < 2)
        begin
            $display("timeout after %0d cycles, halt at %h not reached", cycles, halt_addr);
            timed_out = 1'b1;
        end
    endtask

    initial
    begin
        reset     = 1'b1;
        wb_ack    = 1'b0;
        wb_dat_r  = 8'h00;
        lfsr      = 32'hdfcf;
        in_access = 1'b0;
        wait_left = 2'd0;
        timed_out = 1'b0;
        halt_addr = 16'hffff;
        halt_hits = 0;
        acks      = 0;
        for (test_idx = 0; test_idx < 6 && !timed_out; test_idx++)
        begin
            errors_before = error_count;
            apply_reset(1'b1);
            if (test_idx == 5)
            begin
                wait_for_acks(30);                              // reset lands mid-program.
                apply_reset(1'b0);
            end
            if (!timed_out)
                wait_for_halt;
            $display("test %0d %s: halt %h, %0d errors", test_idx,
                     test_idx == 5 ? "reset mid-program" : "random program",
                     halt_addr, error_count - errors_before);
        end
        $display("tests %0d, checks %0d, errors %0d", test_idx, check_count, error_count);
        if (error_count == 0 && !timed_out)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

//--- source/cpu_alu.sv
module cpu_alu
(
    input  logic [cpu_pkg::data_width-1:0] alu_op,
    input  logic [cpu_pkg::data_width-1:0] a_value,
    input  logic [cpu_pkg::data_width-1:0] b_value,
    output logic [cpu_pkg::data_width-1:0] alu_result,
    output logic                           alu_zero,
    output logic                           alu_carry
);

    logic [cpu_pkg::data_width:0] wide;     // top bit is carry or borrow.

    always_comb
    begin
        case (cpu_pkg::alu_op_e'(alu_op))
            cpu_pkg::alu_add:
                wide = {1'b0, a_value} + {1'b0, b_value};
            cpu_pkg::alu_sub:
                wide = {1'b0, a_value} - {1'b0, b_value};
            cpu_pkg::alu_and:
                wide = {1'b0, a_value & b_value};
            cpu_pkg::alu_or:
                wide = {1'b0, a_value | b_value};
            cpu_pkg::alu_xor:
                wide = {1'b0, a_value ^ b_value};
            default:
                wide = {1'b0, a_value};             // pass A through.
        endcase
    end

    assign alu_result = wide[cpu_pkg::data_width-1:0];
    assign alu_carry  = wide[cpu_pkg::data_width];
    assign alu_zero   = (alu_result == '0);

endmodule

//--- source/cpu_bus_master.sv
module cpu_bus_master
(
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           bus_req,
    input  logic                           bus_we,
    input  logic [cpu_pkg::addr_width-1:0] bus_addr,
    input  logic [cpu_pkg::data_width-1:0] bus_wdata,
    output logic                           bus_done,
    output logic [cpu_pkg::data_width-1:0] bus_rdata,
    output logic [cpu_pkg::addr_width-1:0] wb_adr,
    output logic [cpu_pkg::data_width-1:0] wb_dat_w,
    output logic                           wb_we,
    output logic                           wb_cyc,
    output logic                           wb_stb,
    input  logic [cpu_pkg::data_width-1:0] wb_dat_r,
    input  logic                           wb_ack
);

    logic ending;

    assign ending = wb_cyc && wb_ack;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wb_cyc   <= 1'b0;
            wb_stb   <= 1'b0;
            wb_we    <= 1'b0;
            bus_done <= 1'b0;
        end
        else
        begin
            bus_done <= ending;
            if (bus_req)
            begin
                wb_cyc <= 1'b1;
                wb_stb <= 1'b1;
                wb_we  <= bus_we;
            end
            else if (ending)
            begin
                wb_cyc <= 1'b0;                     // cyc and stb drop together.
                wb_stb <= 1'b0;
                wb_we  <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (bus_req)
        begin
            wb_adr   <= bus_addr;
            wb_dat_w <= bus_wdata;
        end
        if (ending && !wb_we)
            bus_rdata <= wb_dat_r;
    end

endmodule

//--- source/cpu_decode.sv
module cpu_decode
(
    input  logic [7:0]         opcode,
    input  logic [7:0]         opext,
    output logic               need_opext,
    output logic [1:0]         imm_count,
    output cpu_pkg::op_class_e op_class,
    output cpu_pkg::cond_e     cond
);

    always_comb
    begin
        need_opext = 1'b0;
        imm_count  = 2'd0;
        op_class   = cpu_pkg::cls_none;
        cond       = cpu_pkg::cond_none;
        case (cpu_pkg::op_e'(opcode))
            cpu_pkg::op_ld_a_imm, cpu_pkg::op_ld_b_imm:
            begin
                imm_count = 2'd1;
                op_class  = cpu_pkg::cls_load_imm;
            end
            cpu_pkg::op_st_a_mem:
            begin
                imm_count = 2'd2;
                op_class  = cpu_pkg::cls_store_mem;
            end
            cpu_pkg::op_ld_a_mem:
            begin
                imm_count = 2'd2;
                op_class  = cpu_pkg::cls_load_mem;
            end
            cpu_pkg::op_ext:
            begin
                need_opext = 1'b1;
                case (cpu_pkg::alu_op_e'(opext))
                    cpu_pkg::alu_add, cpu_pkg::alu_sub, cpu_pkg::alu_and,
                    cpu_pkg::alu_or, cpu_pkg::alu_xor:
                        op_class = cpu_pkg::cls_alu;
                    default:
                        op_class = cpu_pkg::cls_none;           // unknown ext is a no-op.
                endcase
            end
            cpu_pkg::op_jp, cpu_pkg::op_jz, cpu_pkg::op_jc:
            begin
                imm_count = 2'd2;
                op_class  = cpu_pkg::cls_jump;
                if (opcode == cpu_pkg::op_jz)
                    cond = cpu_pkg::cond_zero;
                else if (opcode == cpu_pkg::op_jc)
                    cond = cpu_pkg::cond_carry;
            end
            default:
                op_class = cpu_pkg::cls_none;               // nop or one-byte no-op.
        endcase
    end

endmodule

//--- source/cpu_pkg.sv
package cpu_pkg;

    localparam int addr_width = 16;
    localparam int data_width = 8;

    localparam logic [addr_width-1:0] reset_vector = 16'h0000;
    localparam logic [1:0]            reset_delay  = 2'd2;     // idle cycles before first fetch.

    typedef enum logic [7:0]
    {
        op_nop      = 8'h00,
        op_ld_a_imm = 8'hb0,
        op_ld_b_imm = 8'hb1,
        op_st_a_mem = 8'hb4,                                    // address low byte first.
        op_ld_a_mem = 8'hb5,
        op_ext      = 8'hce,
        op_jc       = 8'he4,
        op_jz       = 8'he6,
        op_jp       = 8'hf2
    } op_e;

    // extension byte after op_ext.
    typedef enum logic [7:0]
    {
        alu_add = 8'h00,
        alu_sub = 8'h08,
        alu_and = 8'h20,
        alu_or  = 8'h28,
        alu_xor = 8'h30
    } alu_op_e;

    typedef enum logic [2:0]
    {
        cls_none,
        cls_load_imm,
        cls_alu,
        cls_load_mem,
        cls_store_mem,
        cls_jump
    } op_class_e;

    typedef enum logic [1:0] {cond_none, cond_zero, cond_carry} cond_e;

    typedef enum logic [1:0] {src_imm, src_alu, src_mem} a_src_e;

    typedef enum logic [2:0]
    {
        st_idle,
        st_opcode,
        st_opext,
        st_imm_low,
        st_imm_high,
        st_execute,
        st_mem
    } seq_state_e;

endpackage

//--- source/cpu_regfile.sv
module cpu_regfile
(
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           a_we,
    input  logic                           b_we,
    input  logic                           flags_we,
    input  logic [1:0]                     a_src,
    input  logic [cpu_pkg::data_width-1:0] imm_low,
    input  logic [cpu_pkg::data_width-1:0] alu_result,
    input  logic [cpu_pkg::data_width-1:0] bus_rdata,
    input  logic                           alu_zero,
    input  logic                           alu_carry,
    output logic [cpu_pkg::data_width-1:0] a_value,
    output logic [cpu_pkg::data_width-1:0] b_value,
    output logic                           zero,
    output logic                           carry
);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            a_value <= '0;
            b_value <= '0;
            zero    <= 1'b0;
            carry   <= 1'b0;
        end
        else
        begin
            if (a_we)
            begin
                case (cpu_pkg::a_src_e'(a_src))
                    cpu_pkg::src_imm: a_value <= imm_low;
                    cpu_pkg::src_alu: a_value <= alu_result;
                    cpu_pkg::src_mem: a_value <= bus_rdata;
                    default:          a_value <= a_value;
                endcase
            end
            if (b_we)
                b_value <= imm_low;                 // B only takes immediates.
            if (flags_we)
            begin
                zero  <= alu_zero;
                carry <= alu_carry;
            end
        end
    end

endmodule

//--- source/cpu_sequencer.sv
module cpu_sequencer
(
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           bus_done,
    input  logic [cpu_pkg::data_width-1:0] bus_rdata,
    input  logic                           need_opext,
    input  logic [1:0]                     imm_count,
    input  cpu_pkg::op_class_e             op_class,
    input  cpu_pkg::cond_e                 cond,
    input  logic                           zero,
    input  logic                           carry,
    input  logic [cpu_pkg::data_width-1:0] a_value,
    input  logic [cpu_pkg::data_width-1:0] alu_result,
    input  logic                           alu_zero,
    input  logic                           alu_carry,
    output logic                           bus_req,
    output logic                           bus_we,
    output logic [cpu_pkg::addr_width-1:0] bus_addr,
    output logic [cpu_pkg::data_width-1:0] bus_wdata,
    output logic [7:0]                     opcode,
    output logic [7:0]                     opext,
    output logic [7:0]                     alu_op,
    output logic                           a_we,
    output logic                           b_we,
    output logic                           flags_we,
    output logic [1:0]                     a_src,
    output logic [7:0]                     imm_low
);

    cpu_pkg::seq_state_e state;
    cpu_pkg::seq_state_e state_n;

    logic [1:0]                     delay_cnt;
    logic [cpu_pkg::addr_width-1:0] pc;
    logic [cpu_pkg::addr_width-1:0] pc_n;
    logic [cpu_pkg::addr_width-1:0] issue_addr;
    logic [7:0]                     opcode_q;
    logic [7:0]                     imm_high;
    logic                           issue;
    logic                           issue_we;
    logic                           mem_access;
    logic                           cond_met;

    // decode the opcode byte in the cycle it arrives.
    assign opcode     = (state == cpu_pkg::st_opcode && bus_done) ? bus_rdata : opcode_q;
    assign alu_op     = opext;
    assign mem_access = (op_class == cpu_pkg::cls_load_mem) ||
                        (op_class == cpu_pkg::cls_store_mem);
    assign cond_met   = (cond == cpu_pkg::cond_none) ||
                        (cond == cpu_pkg::cond_zero && zero) ||
                        (cond == cpu_pkg::cond_carry && carry);

    // #########################################################################
    // next state and bus request
    // #########################################################################

    always_comb
    begin
        state_n  = state;
        pc_n     = pc;
        issue_we = 1'b0;
        case (state)
            cpu_pkg::st_idle:
                if (delay_cnt == cpu_pkg::reset_delay)
                    state_n = cpu_pkg::st_opcode;
            cpu_pkg::st_opcode:
                if (bus_done)
                begin
                    pc_n = pc + 1'b1;
                    if (need_opext)
                        state_n = cpu_pkg::st_opext;
                    else if (imm_count != 2'd0)
                        state_n = cpu_pkg::st_imm_low;
                    else
                        state_n = cpu_pkg::st_execute;
                end
            cpu_pkg::st_opext:
                if (bus_done)
                begin
                    pc_n    = pc + 1'b1;
                    state_n = (imm_count != 2'd0) ? cpu_pkg::st_imm_low : cpu_pkg::st_execute;
                end
            cpu_pkg::st_imm_low:
                if (bus_done)
                begin
                    pc_n    = pc + 1'b1;
                    state_n = (imm_count == 2'd2) ? cpu_pkg::st_imm_high : cpu_pkg::st_execute;
                end
            cpu_pkg::st_imm_high:
                if (bus_done)
                begin
                    pc_n    = pc + 1'b1;
                    state_n = cpu_pkg::st_execute;
                end
            cpu_pkg::st_execute:
            begin
                if (op_class == cpu_pkg::cls_jump && cond_met)
                    pc_n = {imm_high, imm_low};
                state_n  = mem_access ? cpu_pkg::st_mem : cpu_pkg::st_opcode;
                issue_we = (op_class == cpu_pkg::cls_store_mem);
            end
            cpu_pkg::st_mem:
                if (bus_done)
                    state_n = cpu_pkg::st_opcode;
            default:
                state_n = cpu_pkg::st_idle;
        endcase
    end

    // entering any bus state starts exactly one access.
    assign issue      = (state_n != state) && (state_n != cpu_pkg::st_execute);
    assign issue_addr = (state == cpu_pkg::st_execute && mem_access) ? {imm_high, imm_low} : pc_n;

    // #########################################################################
    // register file controls
    // #########################################################################

    always_comb
    begin
        a_we     = 1'b0;
        b_we     = 1'b0;
        flags_we = 1'b0;
        a_src    = cpu_pkg::src_imm;
        if (state == cpu_pkg::st_execute)
        begin
            case (op_class)
                cpu_pkg::cls_load_imm:
                begin
                    a_we = (opcode_q == cpu_pkg::op_ld_a_imm);
                    b_we = (opcode_q == cpu_pkg::op_ld_b_imm);
                end
                cpu_pkg::cls_alu:
                begin
                    a_src    = cpu_pkg::src_alu;
                    a_we     = (alu_result != a_value);      // skip writes that change nothing.
                    flags_we = (alu_zero != zero) || (alu_carry != carry);
                end
                default:
                    a_we = 1'b0;
            endcase
        end
        else if (state == cpu_pkg::st_mem && bus_done && !bus_we)
        begin
            a_src = cpu_pkg::src_mem;
            a_we  = 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state     <= cpu_pkg::st_idle;
            delay_cnt <= 2'd0;
            pc        <= cpu_pkg::reset_vector;
            bus_req   <= 1'b0;
            bus_we    <= 1'b0;
        end
        else
        begin
            state   <= state_n;
            pc      <= pc_n;
            bus_req <= issue;
            if (issue)
                bus_we <= issue_we;
            if (state == cpu_pkg::st_idle && delay_cnt != cpu_pkg::reset_delay)
                delay_cnt <= delay_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (issue)
        begin
            bus_addr  <= issue_addr;
            bus_wdata <= a_value;                           // only used by stores.
        end
        if (bus_done)
        begin
            case (state)
                cpu_pkg::st_opcode:   opcode_q <= bus_rdata;
                cpu_pkg::st_opext:    opext    <= bus_rdata;
                cpu_pkg::st_imm_low:  imm_low  <= bus_rdata;
                cpu_pkg::st_imm_high: imm_high <= bus_rdata;
                default:              imm_high <= imm_high;
            endcase
        end
    end

endmodule

//--- source/cpu_top.sv
module cpu_top
(
    input  logic        clk,
    input  logic        reset,
    output logic [15:0] wb_adr,
    output logic [7:0]  wb_dat_w,
    input  logic [7:0]  wb_dat_r,
    output logic        wb_we,
    output logic        wb_cyc,
    output logic        wb_stb,
    input  logic        wb_ack
);

    logic                           bus_req;
    logic                           bus_we;
    logic [cpu_pkg::addr_width-1:0] bus_addr;
    logic [cpu_pkg::data_width-1:0] bus_wdata;
    logic                           bus_done;
    logic [cpu_pkg::data_width-1:0] bus_rdata;
    logic [7:0]                     opcode;
    logic [7:0]                     opext;
    logic [7:0]                     alu_op;
    logic [7:0]                     imm_low;
    logic                           need_opext;
    logic [1:0]                     imm_count;
    cpu_pkg::op_class_e             op_class;
    cpu_pkg::cond_e                 cond;
    logic                           a_we;
    logic                           b_we;
    logic                           flags_we;
    logic [1:0]                     a_src;
    logic [cpu_pkg::data_width-1:0] a_value;
    logic [cpu_pkg::data_width-1:0] b_value;
    logic [cpu_pkg::data_width-1:0] alu_result;
    logic                           zero;
    logic                           carry;
    logic                           alu_zero;
    logic                           alu_carry;

    // all nets share the port names of the blocks.
    cpu_sequencer  u_sequencer  (.*);
    cpu_decode     u_decode     (.*);
    cpu_alu        u_alu        (.*);
    cpu_regfile    u_regfile    (.*);
    cpu_bus_master u_bus_master (.*);

endmodule
